// ==== rtl/tcache_settings.svh ====
// Build settings of the translation cache: sizes, geometry and replacement policy.
`ifndef TCACHE_SETTINGS_SVH
`define TCACHE_SETTINGS_SVH

// ************************************************************************
// Geometry
// ************************************************************************

`define TCACHE_KEY_WIDTH     20   // Virtual page key.
`define TCACHE_PAYLOAD_WIDTH 32   // Physical page and flags.
`define TCACHE_ENTRIES       64
`define TCACHE_WAYS          4

`define TCACHE_SETS          (`TCACHE_ENTRIES / `TCACHE_WAYS)
`define TCACHE_SET_WIDTH     $clog2(`TCACHE_SETS)
`define TCACHE_WAY_WIDTH     $clog2(`TCACHE_WAYS)

// ************************************************************************
// Replacement policy
// ************************************************************************

`define TCACHE_POLICY_LRU    0    // Pseudo-LRU tree.
`define TCACHE_POLICY_RR     1    // Round robin per set.
`define TCACHE_POLICY_RANDOM 2    // Free-running LFSR.

`define TCACHE_POLICY        `TCACHE_POLICY_LRU

`endif

// ==== rtl/tcache_pkg.sv ====
// Shared types of the translation cache: key, tag, index, way and front-end state.
`include "tcache_settings.svh"

package tcache_pkg;

  // Full request key as presented by the requester.
  typedef logic [`TCACHE_KEY_WIDTH-1:0] key_t;

  // Stored tag, the key without its set bits.
  typedef logic [`TCACHE_KEY_WIDTH-`TCACHE_SET_WIDTH-1:0] tag_t;

  typedef logic [`TCACHE_SET_WIDTH-1:0] set_idx_t;     // Set select.
  typedef logic [`TCACHE_WAY_WIDTH-1:0] way_t;         // Way number.

  typedef logic [`TCACHE_PAYLOAD_WIDTH-1:0] payload_t;

  // Four-phase front end.
  // IDLE waits for req, ACCESS runs the lookup or fill,
  // RESPOND holds ack until req drops.
  typedef enum logic [1:0] {
    IDLE    = 2'd0,
    ACCESS  = 2'd1,
    RESPOND = 2'd2
  } front_state_e;

endpackage

// ==== rtl/tag_ram.sv ====
// One cache way holding valid, tag and payload per set, with combinational compare.
`timescale 1ns/1ps
`include "tcache_settings.svh"

module tag_ram (
  input  logic                 clk,
  input  logic                 resetn,
  input  tcache_pkg::set_idx_t set_idx_i,
  input  tcache_pkg::tag_t     tag_i,
  input  logic                 we_i,
  input  tcache_pkg::payload_t payload_i,
  output logic                 hit_o,
  output tcache_pkg::payload_t payload_o
);

  // ************************************************************************
  // Storage
  // ************************************************************************

  logic [`TCACHE_SETS-1:0] valid_q;                  // One bit per set.
  tcache_pkg::tag_t        tag_mem     [`TCACHE_SETS];
  tcache_pkg::payload_t    payload_mem [`TCACHE_SETS];

  // Valid bits, the only state cleared by reset.
  always_ff @(posedge clk) begin
    if (!resetn) begin
      valid_q <= '0;
    end else if (we_i) begin
      valid_q[set_idx_i] <= 1'b1;                    // Entry now live.
    end
  end

  // Tag and payload arrays.
  always_ff @(posedge clk) begin
    if (we_i) begin
      tag_mem[set_idx_i]     <= tag_i;
      payload_mem[set_idx_i] <= payload_i;
    end
  end

  // ************************************************************************
  // Read side
  // ************************************************************************

  // Compare against the indexed entry in the same cycle.
  assign hit_o     = valid_q[set_idx_i] && (tag_mem[set_idx_i] == tag_i);
  assign payload_o = payload_mem[set_idx_i];        // Qualified by hit_o.

endmodule

// ==== rtl/victim_select.sv ====
// Per-set replacement state and victim way for pseudo-LRU, round robin or LFSR policy.
`timescale 1ns/1ps
`include "tcache_settings.svh"

module victim_select (
  input  logic                 clk,
  input  logic                 resetn,
  input  tcache_pkg::set_idx_t set_idx_i,
  input  logic                 access_i,
  input  logic                 hit_i,
  input  tcache_pkg::way_t     access_way_i,
  output tcache_pkg::way_t     victim_way_o
);

  generate
    if (`TCACHE_POLICY == `TCACHE_POLICY_LRU) begin : g_lru

      // ************************************************************************
      // Pseudo-LRU tree, 3 bits per set
      // ************************************************************************
      // Bit 2 is the root, set when the lower half was used last.
      // Bit 1 covers ways 2/3, set when way 2 was used last.
      // Bit 0 covers ways 0/1, set when way 0 was used last.

      logic [2:0] tree_q [`TCACHE_SETS];
      logic [2:0] tree_cur;

      always_ff @(posedge clk) begin
        if (!resetn) begin
          for (int s = 0; s < `TCACHE_SETS; s++) begin
            tree_q[s] <= 3'b000;
          end
        end else if (access_i) begin
          tree_q[set_idx_i][2] <= ~access_way_i[1];  // Point away from touched half.
          if (access_way_i[1]) begin
            tree_q[set_idx_i][1] <= ~access_way_i[0];
          end else begin
            tree_q[set_idx_i][0] <= ~access_way_i[0];
          end
        end
      end

      assign tree_cur = tree_q[set_idx_i];

      // Follow the branches that were not used last.
      assign victim_way_o = tree_cur[2] ? {1'b1, tree_cur[1]} : {1'b0, tree_cur[0]};

    end else if (`TCACHE_POLICY == `TCACHE_POLICY_RR) begin : g_rr

      // ************************************************************************
      // Round robin, one counter per set
      // ************************************************************************

      tcache_pkg::way_t rr_q [`TCACHE_SETS];

      // Advance only when a fill misses and claims a way.
      always_ff @(posedge clk) begin
        if (!resetn) begin
          for (int s = 0; s < `TCACHE_SETS; s++) begin
            rr_q[s] <= '0;
          end
        end else if (access_i && !hit_i) begin
          rr_q[set_idx_i] <= rr_q[set_idx_i] + 1'b1;  // Wraps at the way count.
        end
      end

      assign victim_way_o = rr_q[set_idx_i];

    end else begin : g_random

      // ************************************************************************
      // Random, free-running 8-bit LFSR
      // ************************************************************************

      logic [7:0] lfsr_q;

      always_ff @(posedge clk) begin
        if (!resetn) begin
          lfsr_q <= 8'h01;                           // Nonzero seed.
        end else begin
          lfsr_q <= {lfsr_q[6:0], lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3]};
        end
      end

      // Low bits pick the way, shared by all sets.
      assign victim_way_o = lfsr_q[`TCACHE_WAY_WIDTH-1:0];

    end
  endgenerate

endmodule

// ==== rtl/associative_cache.sv ====
// Set-associative cache core: key split, way array, hit resolve and write steering.
`timescale 1ns/1ps
`include "tcache_settings.svh"

module associative_cache (
  input  logic                 clk,
  input  logic                 resetn,
  input  tcache_pkg::key_t     key_i,
  input  logic                 we_i,
  input  logic                 valid_i,
  input  tcache_pkg::payload_t payload_i,
  output logic                 hit_o,
  output tcache_pkg::payload_t payload_o
);

  // ************************************************************************
  // Key split
  // ************************************************************************

  tcache_pkg::set_idx_t set_idx;
  tcache_pkg::tag_t     tag;

  assign set_idx = key_i[`TCACHE_SET_WIDTH-1:0];                    // Low bits.
  assign tag     = key_i[`TCACHE_KEY_WIDTH-1:`TCACHE_SET_WIDTH];   // The rest.

  logic [`TCACHE_WAYS-1:0] way_hit;
  logic [`TCACHE_WAYS-1:0] way_we;
  tcache_pkg::payload_t    way_payload [`TCACHE_WAYS];

  tcache_pkg::way_t hit_way;
  tcache_pkg::way_t victim_way;
  tcache_pkg::way_t access_way;
  logic             access;

  // ************************************************************************
  // Hit resolve
  // ************************************************************************

  // Highest matching way wins. At most one should match.
  always_comb begin
    hit_way = '0;
    for (int w = 0; w < `TCACHE_WAYS; w++) begin
      if (way_hit[w]) begin
        hit_way = tcache_pkg::way_t'(w);
      end
    end
  end

  assign hit_o     = |way_hit;
  assign payload_o = way_payload[hit_way];

  // Touched way for the replacement state.
  assign access     = valid_i && (hit_o || we_i);
  assign access_way = hit_o ? hit_way : victim_way;

  victim_select u_victim (
    .clk         (clk),
    .resetn      (resetn),
    .set_idx_i   (set_idx),
    .access_i    (access),
    .hit_i       (hit_o),
    .access_way_i(access_way),
    .victim_way_o(victim_way)
  );

  // ************************************************************************
  // Ways
  // ************************************************************************

  genvar w;
  generate
    for (w = 0; w < `TCACHE_WAYS; w++) begin : g_way
      // Refill of a present key goes to its own way, never a second copy.
      assign way_we[w] = valid_i && we_i && (access_way == tcache_pkg::way_t'(w));

      tag_ram u_way (
        .clk      (clk),
        .resetn   (resetn),
        .set_idx_i(set_idx),
        .tag_i    (tag),
        .we_i     (way_we[w]),
        .payload_i(payload_i),
        .hit_o    (way_hit[w]),
        .payload_o(way_payload[w])
      );
    end
  endgenerate

endmodule

// ==== rtl/translation_cache.sv ====
// Translation cache top with a four-phase req/ack front end around the associative cache.
`timescale 1ns/1ps

module translation_cache (
  input  logic                 clk,
  input  logic                 resetn,
  input  logic                 req_i,
  input  logic                 fill_i,
  input  tcache_pkg::key_t     key_i,
  input  tcache_pkg::payload_t fill_payload_i,
  output logic                 ack_o,
  output logic                 hit_o,
  output tcache_pkg::payload_t payload_o
);

  tcache_pkg::front_state_e state_q;

  // Request capture.
  logic                 fill_q;
  tcache_pkg::key_t     key_q;
  tcache_pkg::payload_t fill_payload_q;

  // Results held for the requester.
  logic                 ack_q;
  logic                 hit_q;
  tcache_pkg::payload_t payload_q;

  logic                 access_cycle;
  logic                 cache_hit;
  tcache_pkg::payload_t cache_payload;

  assign access_cycle = (state_q == tcache_pkg::ACCESS);

  // ************************************************************************
  // Front-end FSM
  // ************************************************************************

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state_q <= tcache_pkg::IDLE;
      fill_q  <= 1'b0;
      ack_q   <= 1'b0;
      hit_q   <= 1'b0;
    end else begin
      case (state_q)
        tcache_pkg::IDLE: begin
          if (req_i) begin
            fill_q  <= fill_i;
            state_q <= tcache_pkg::ACCESS;
          end
        end
        tcache_pkg::ACCESS: begin
          hit_q   <= cache_hit;                      // Presence before any write.
          ack_q   <= 1'b1;
          state_q <= tcache_pkg::RESPOND;
        end
        tcache_pkg::RESPOND: begin
          if (!req_i) begin                          // Requester released.
            ack_q   <= 1'b0;
            state_q <= tcache_pkg::IDLE;
          end
        end
        default: state_q <= tcache_pkg::IDLE;
      endcase
    end
  end

  // Key and payload registers.
  always_ff @(posedge clk) begin
    if (state_q == tcache_pkg::IDLE && req_i) begin
      key_q          <= key_i;
      fill_payload_q <= fill_payload_i;
    end
    if (access_cycle) begin
      payload_q <= cache_payload;
    end
  end

  // One access per handshake, in the single ACCESS cycle.
  associative_cache u_cache (
    .clk      (clk),
    .resetn   (resetn),
    .key_i    (key_q),
    .we_i     (access_cycle && fill_q),
    .valid_i  (access_cycle),
    .payload_i(fill_payload_q),
    .hit_o    (cache_hit),
    .payload_o(cache_payload)
  );

  assign ack_o     = ack_q;
  assign hit_o     = hit_q;
  assign payload_o = payload_q;

endmodule

// ==== test/translation_cache_chk.sv ====
// Handshake and reset checks of the translation cache, bound into its top level.
`timescale 1ns/1ps

module translation_cache_chk (
  input logic                 clk,
  input logic                 resetn,
  input logic                 req_i,
  input logic                 ack_i,
  input logic                 hit_i,
  input tcache_pkg::payload_t payload_i
);

  int violations = 0;   // Failed assertions so far.

  // ack low through reset and right after it.
  reset_ack_low: assert property (@(posedge clk) !resetn |=> !ack_i)
    else begin
      violations++;
      $error("ack_o was high during or right after reset");
    end

  ack_rise_with_req: assert property (@(posedge clk) disable iff (!resetn)
    $rose(ack_i) |-> $past(req_i))
    else begin
      violations++;
      $error("ack_o rose without a pending request");
    end

  // ack drops only once req was seen low.
  ack_fall_after_req: assert property (@(posedge clk) disable iff (!resetn)
    $fell(ack_i) |-> !$past(req_i))
    else begin
      violations++;
      $error("ack_o fell while the request was still high");
    end

  results_hold: assert property (@(posedge clk) disable iff (!resetn)
    ack_i && $past(ack_i) |-> $stable(hit_i) && (!hit_i || $stable(payload_i)))
    else begin
      violations++;
      $error("hit_o or payload_o changed while ack_o was high");
    end

endmodule

bind translation_cache translation_cache_chk u_chk (
  .clk      (clk),
  .resetn   (resetn),
  .req_i    (req_i),
  .ack_i    (ack_o),
  .hit_i    (hit_o),
  .payload_i(payload_o)
);

// ==== test/tb_translation_cache.sv ====
// Testbench for the translation cache: four-phase driver, shadow model and random traffic.
`timescale 1ns/1ps
`include "tcache_settings.svh"

module tb_translation_cache;

  localparam int CLK_PERIOD    = 100;
  localparam int DIRECTED_TXNS = 64;
  localparam int RANDOM_TXNS   = 300;
  localparam int TXN_COUNT     = DIRECTED_TXNS + RANDOM_TXNS;

  logic                 clk;
  logic                 resetn;
  logic                 req;
  logic                 fill;
  tcache_pkg::key_t     key;
  tcache_pkg::payload_t fill_payload;
  logic                 ack;
  logic                 hit;
  tcache_pkg::payload_t payload;

  int          errors;
  logic [31:0] rng_state;

  // Shadow model of every set and way.
  logic                 sh_valid   [`TCACHE_SETS][`TCACHE_WAYS];
  tcache_pkg::tag_t     sh_tag     [`TCACHE_SETS][`TCACHE_WAYS];
  tcache_pkg::payload_t sh_payload [`TCACHE_SETS][`TCACHE_WAYS];
  logic                 lo_recent  [`TCACHE_SETS];  // Lower half used last.
  logic                 w2_recent  [`TCACHE_SETS];  // Way 2 used last in upper pair.
  logic                 w0_recent  [`TCACHE_SETS];  // Way 0 used last in lower pair.

  translation_cache dut0 (
    .clk           (clk),
    .resetn        (resetn),
    .req_i         (req),
    .fill_i        (fill),
    .key_i         (key),
    .fill_payload_i(fill_payload),
    .ack_o         (ack),
    .hit_o         (hit),
    .payload_o     (payload)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Watchdog, sized from the transaction count.
  initial begin
    #((TXN_COUNT * 10 + 1000) * CLK_PERIOD);
    $display("Watchdog timeout: the run did not finish within %0d cycles",
             TXN_COUNT * 10 + 1000);
    $display("=== FAIL ===");
    $finish;
  end

  function logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic tcache_pkg::key_t make_key(input tcache_pkg::tag_t t, input int s);
    return {t, tcache_pkg::set_idx_t'(s)};
  endfunction

  // ************************************************************************
  // Shadow model
  // ************************************************************************

  // Victim follows the branches not used last.
  function automatic int model_victim(input tcache_pkg::set_idx_t s);
    if (lo_recent[s]) begin
      return w2_recent[s] ? 3 : 2;
    end
    return w0_recent[s] ? 1 : 0;
  endfunction

  function automatic void model_touch(input tcache_pkg::set_idx_t s, input int w);
    lo_recent[s] = (w < 2);
    if (w >= 2) begin
      w2_recent[s] = (w == 2);
    end else begin
      w0_recent[s] = (w == 0);
    end
  endfunction

  function automatic void model_access(input logic op_fill, input tcache_pkg::key_t k,
                                       input tcache_pkg::payload_t pl, output logic exp_hit,
                                       output tcache_pkg::payload_t exp_pl);
    tcache_pkg::set_idx_t s;
    tcache_pkg::tag_t     t;
    int                   way;
    s       = k[`TCACHE_SET_WIDTH-1:0];
    t       = k[`TCACHE_KEY_WIDTH-1:`TCACHE_SET_WIDTH];
    exp_hit = 1'b0;
    exp_pl  = '0;
    way     = 0;
    for (int w = 0; w < `TCACHE_WAYS; w++) begin
      if (sh_valid[s][w] && sh_tag[s][w] == t) begin
        exp_hit = 1'b1;
        exp_pl  = sh_payload[s][w];
        way     = w;
      end
    end
    if (op_fill) begin
      if (!exp_hit) way = model_victim(s);   // Present key stays in its way.
      sh_valid[s][way]   = 1'b1;
      sh_tag[s][way]     = t;
      sh_payload[s][way] = pl;
    end
    if (op_fill || exp_hit) model_touch(s, way);
  endfunction

  // ************************************************************************
  // Requester
  // ************************************************************************

  // Full four-phase transaction, holding req for extra cycles.
  task automatic transact(input logic op_fill, input tcache_pkg::key_t k,
                          input tcache_pkg::payload_t pl, input int hold,
                          output logic got_hit, output tcache_pkg::payload_t got_pl);
    req          = 1'b1;
    fill         = op_fill;
    key          = k;
    fill_payload = pl;
    do begin
      @(negedge clk);
    end while (!ack);
    got_hit = hit;
    got_pl  = payload;
    repeat (hold) begin
      @(negedge clk);
      assert (hit == got_hit && (!got_hit || payload == got_pl)) else begin
        $display("Mismatch at %0d ns: results changed while ack was held", $time);
        errors++;
      end
    end
    req = 1'b0;
    key = tcache_pkg::key_t'(next_rand());   // Free to change once released.
    do begin
      @(negedge clk);
    end while (ack);
  endtask

  task automatic check_access(input logic op_fill, input tcache_pkg::key_t k,
                              input tcache_pkg::payload_t pl, input int hold,
                              output logic got_hit);
    logic                 exp_hit;
    tcache_pkg::payload_t exp_pl;
    tcache_pkg::payload_t got_pl;
    transact(op_fill, k, pl, hold, got_hit, got_pl);
    model_access(op_fill, k, pl, exp_hit, exp_pl);
    assert (got_hit == exp_hit) else begin
      $display("Mismatch at %0d ns: %s of key %h gave hit %b, model expects %b", $time,
               op_fill ? "fill" : "lookup", k, got_hit, exp_hit);
      errors++;
    end
    if (!op_fill && exp_hit) begin
      assert (got_pl == exp_pl) else begin
        $display("Mismatch at %0d ns: lookup of key %h gave payload %h, expected %h",
                 $time, k, got_pl, exp_pl);
        errors++;
      end
    end
  endtask

  // Directed request with a fixed expected hit.
  task automatic expect_hit(input logic op_fill, input tcache_pkg::key_t k,
                            input tcache_pkg::payload_t pl, input logic want);
    logic h;
    check_access(op_fill, k, pl, 0, h);
    assert (h == want) else begin
      $display("Mismatch at %0d ns: key %h gave hit %b, expected %b", $time, k, h, want);
      errors++;
    end
  endtask

  // ************************************************************************
  // Test sequence
  // ************************************************************************

  initial begin
    logic                 h;
    logic [31:0]          r;
    tcache_pkg::key_t     k;
    tcache_pkg::payload_t pl;
    int                   total;
    req          = 1'b0;
    fill         = 1'b0;
    key          = '0;
    fill_payload = '0;
    resetn       = 1'b0;
    errors       = 0;
    rng_state    = 32'h17e9;
    for (int s = 0; s < `TCACHE_SETS; s++) begin
      lo_recent[s] = 1'b0;
      w2_recent[s] = 1'b0;
      w0_recent[s] = 1'b0;
      for (int w = 0; w < `TCACHE_WAYS; w++) begin
        sh_valid[s][w]   = 1'b0;
        sh_tag[s][w]     = '0;
        sh_payload[s][w] = '0;
      end
    end
    repeat (8) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;
    assert (ack == 1'b0) else begin
      $display("Mismatch at %0d ns: ack high before the first request", $time);
      errors++;
    end

    // Empty cache misses everywhere.
    repeat (8) expect_hit(1'b0, tcache_pkg::key_t'(next_rand()), '0, 1'b0);

    // Fill, lookup, refill in place.
    k = make_key(16'h0abc, 3);
    expect_hit(1'b1, k, 32'h1111_0001, 1'b0);
    expect_hit(1'b0, k, '0, 1'b1);
    expect_hit(1'b1, k, 32'h2222_0002, 1'b1);
    expect_hit(1'b0, k, '0, 1'b1);

    // Full set, one refill, no key lost.
    for (int i = 1; i <= 4; i++) begin
      expect_hit(1'b1, make_key(tcache_pkg::tag_t'(16'h0100 + i), 5), 32'h5500 + i, 1'b0);
    end
    expect_hit(1'b1, make_key(16'h0102, 5), 32'h55aa_0102, 1'b1);
    for (int i = 1; i <= 4; i++) begin
      expect_hit(1'b0, make_key(tcache_pkg::tag_t'(16'h0100 + i), 5), '0, 1'b1);
    end

    // A, B, C, D fill ways 0, 2, 1, 3; touching A leaves B as victim for E.
    for (int i = 10; i <= 13; i++) begin
      expect_hit(1'b1, make_key(tcache_pkg::tag_t'(i << 8), 9), 32'h9900 + i, 1'b0);
    end
    expect_hit(1'b0, make_key(16'h0a00, 9), '0, 1'b1);
    expect_hit(1'b1, make_key(16'h0e00, 9), 32'h9900_000e, 1'b0);
    expect_hit(1'b0, make_key(16'h0a00, 9), '0, 1'b1);
    expect_hit(1'b0, make_key(16'h0b00, 9), '0, 1'b0);
    expect_hit(1'b0, make_key(16'h0c00, 9), '0, 1'b1);
    expect_hit(1'b0, make_key(16'h0d00, 9), '0, 1'b1);
    expect_hit(1'b0, make_key(16'h0e00, 9), '0, 1'b1);

    // Same tag in every set.
    for (int s = 0; s < `TCACHE_SETS; s++) begin
      expect_hit(1'b1, make_key(16'h5a5a, s), 32'h5a00 + s, 1'b0);
    end
    for (int s = 0; s < `TCACHE_SETS; s++) begin
      expect_hit(1'b0, make_key(16'h5a5a, s), '0, 1'b1);
    end

    // Random traffic on a small tag pool, with back-pressure and gaps.
    for (int i = 0; i < RANDOM_TXNS; i++) begin
      r  = next_rand();
      pl = next_rand();
      k  = {13'h0, r[18:16], r[3:0]};
      check_access(r[8], k, pl, int'(r[11:10]), h);
      repeat (int'(r[13:12])) @(negedge clk);
    end

    total = errors + dut0.u_chk.violations;
    $display("Errors: %0d data mismatches, %0d protocol violations", errors,
             dut0.u_chk.violations);
    if (total == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== tb.f ====
+incdir+rtl
rtl/tcache_pkg.sv
rtl/tag_ram.sv
rtl/victim_select.sv
rtl/associative_cache.sv
rtl/translation_cache.sv
test/translation_cache_chk.sv
test/tb_translation_cache.sv

// ==== Makefile ====
TOP = tb_translation_cache

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f --top-module $(TOP) -o sim

run: compile
	@out="$$(./obj_dir/sim +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "=== PASS ==="

clean:
	rm -rf obj_dir
